/* src/video_pkg.sv */
`default_nettype none

package video_pkg;

  // Framebuffer edge in pixels, square screen
  localparam int FB_SIZE = 16;
  localparam int COORD_W = $clog2(FB_SIZE);
  localparam int FB_DEPTH = FB_SIZE * FB_SIZE;

  // RGB565 channel widths
  localparam int RED_W = 5;
  localparam int GREEN_W = 6;
  localparam int BLUE_W = 5;

  typedef logic [COORD_W-1:0] coord_t;

  // One extra bit so the raster counter can point past the framebuffer
  typedef logic [COORD_W:0] scan_coord_t;

  typedef logic [RED_W+GREEN_W+BLUE_W-1:0] pixel_t;

  // Row times FB_SIZE plus column
  typedef logic [2*COORD_W-1:0] fb_addr_t;

endpackage

`default_nettype wire

/* src/gpu_pkg.sv */
`default_nettype none

package gpu_pkg;

  import video_pkg::*;

  localparam int CMD_W = 32;

  // Opcode sits in the top two bits of the command word
  typedef enum logic [1:0] {
    OP_CLEAR     = 2'd0,
    OP_SET_COLOR = 2'd1,
    OP_PLOT      = 2'd2,
    OP_FILL_RECT = 2'd3
  } gpu_op_t;

  localparam int OP_LSB = CMD_W - $bits(gpu_op_t);

  // Field positions inside the command word
  localparam int COLOR_LSB = 0;
  localparam int X0_LSB = 12;
  localparam int Y0_LSB = 8;
  localparam int X1_LSB = 4;
  localparam int Y1_LSB = 0;
  localparam int PLOT_X_LSB = 4;
  localparam int PLOT_Y_LSB = 0;

  // Corners already ordered, x0 <= x1 and y0 <= y1
  typedef struct packed {
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    pixel_t color;
  } draw_job_t;

endpackage

`default_nettype wire

/* src/gpu_ifs.sv */
`timescale 1ns/100ps
`default_nettype none

// Draw job handoff from decode to the raster engine
interface draw_cmd_if import gpu_pkg::*; ();

  logic      job_valid;
  draw_job_t job;
  logic      busy;

  modport source (
    output job_valid,
    output job,
    input  busy
  );

  modport sink (
    input  job_valid,
    input  job,
    output busy
  );

endinterface

// Framebuffer write port, takes effect on the edge where we is high
interface fb_write_if import video_pkg::*; ();

  logic     we;
  fb_addr_t addr;
  pixel_t   data;

  modport source (
    output we,
    output addr,
    output data
  );

  modport sink (
    input we,
    input addr,
    input data
  );

endinterface

`default_nettype wire

/* src/gpu_cmd_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_cmd_decode import gpu_pkg::*, video_pkg::*; (
  input  logic             Clk,
  input  logic             rst_n,
  input  logic             cmd_valid,
  input  logic [CMD_W-1:0] cmd_data,
  draw_cmd_if.source       cmd,
  output logic             pending
);

  gpu_op_t   op;
  logic      accept;
  pixel_t    color_q;
  coord_t    ax;
  coord_t    ay;
  coord_t    bx;
  coord_t    by;
  logic      job_valid_q;
  draw_job_t job_q;

  assign op = gpu_op_t'(cmd_data[OP_LSB +: $bits(gpu_op_t)]);

  // Busy engine or a job still in flight means the command is lost
  assign accept = cmd_valid && !cmd.busy && !job_valid_q;

  assign ax = cmd_data[X0_LSB +: COORD_W];
  assign ay = cmd_data[Y0_LSB +: COORD_W];
  assign bx = cmd_data[X1_LSB +: COORD_W];
  assign by = cmd_data[Y1_LSB +: COORD_W];

  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      color_q     <= '0;
      job_valid_q <= 1'b0;
    end else begin
      job_valid_q <= accept && (op != OP_SET_COLOR);
      if (accept && op == OP_SET_COLOR) begin
        color_q <= cmd_data[COLOR_LSB +: $bits(pixel_t)];
      end
    end
  end

  // Job payload, only meaningful with the strobe
  always_ff @(posedge Clk) begin
    if (accept) begin
      case (op)
        OP_CLEAR: begin
          job_q <= '{x0: '0, y0: '0, x1: coord_t'(FB_SIZE - 1),
                     y1: coord_t'(FB_SIZE - 1), color: '0};
        end
        OP_PLOT: begin
          job_q.x0    <= cmd_data[PLOT_X_LSB +: COORD_W];
          job_q.x1    <= cmd_data[PLOT_X_LSB +: COORD_W];
          job_q.y0    <= cmd_data[PLOT_Y_LSB +: COORD_W];
          job_q.y1    <= cmd_data[PLOT_Y_LSB +: COORD_W];
          job_q.color <= color_q;
        end
        OP_FILL_RECT: begin
          // Corners may come in either order
          job_q.x0    <= (ax < bx) ? ax : bx;
          job_q.x1    <= (ax < bx) ? bx : ax;
          job_q.y0    <= (ay < by) ? ay : by;
          job_q.y1    <= (ay < by) ? by : ay;
          job_q.color <= color_q;
        end
        default: begin
          job_q <= job_q;
        end
      endcase
    end
  end

  assign cmd.job_valid = job_valid_q;
  assign cmd.job       = job_q;
  assign pending       = job_valid_q;

endmodule

`default_nettype wire

/* src/gpu_raster_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_raster_engine import video_pkg::*; (
  input  logic       Clk,
  input  logic       rst_n,
  draw_cmd_if.sink   cmd,
  fb_write_if.source fb
);

  logic   busy_q;
  coord_t x_q;
  coord_t y_q;
  coord_t x0_q;
  coord_t x1_q;
  coord_t y1_q;
  pixel_t color_q;
  logic   row_end;
  logic   last_pixel;

  assign row_end    = (x_q == x1_q);
  assign last_pixel = row_end && (y_q == y1_q);

  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (cmd.job_valid) begin
      busy_q <= 1'b1;
    end else if (busy_q && last_pixel) begin
      busy_q <= 1'b0;
    end
  end

  // Walk the rectangle row by row, x fastest
  always_ff @(posedge Clk) begin
    if (cmd.job_valid) begin
      x_q     <= cmd.job.x0;
      y_q     <= cmd.job.y0;
      x0_q    <= cmd.job.x0;
      x1_q    <= cmd.job.x1;
      y1_q    <= cmd.job.y1;
      color_q <= cmd.job.color;
    end else if (busy_q) begin
      if (row_end) begin
        x_q <= x0_q;
        y_q <= y_q + 1'b1;
      end else begin
        x_q <= x_q + 1'b1;
      end
    end
  end

  assign cmd.busy = busy_q;

  // One write per busy cycle
  assign fb.we   = busy_q;
  assign fb.addr = {y_q, x_q};
  assign fb.data = color_q;

endmodule

`default_nettype wire

/* src/gpu_framebuffer.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_framebuffer import video_pkg::*; (
  input  logic     Clk,
  fb_write_if.sink fb,
  input  fb_addr_t rd_addr,
  output pixel_t   rd_data
);

  pixel_t mem [FB_DEPTH];

  always_ff @(posedge Clk) begin
    if (fb.we) begin
      mem[fb.addr] <= fb.data;
    end
  end

  // Read before write on an address collision
  always_ff @(posedge Clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* src/gpu_scanout.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_scanout import video_pkg::*; (
  input  logic               Clk,
  input  logic               rst_n,
  input  logic               scan_valid,
  input  scan_coord_t        scan_x,
  input  scan_coord_t        scan_y,
  output fb_addr_t           rd_addr,
  input  pixel_t             rd_data,
  output logic               pixel_valid,
  output logic [RED_W-1:0]   red,
  output logic [GREEN_W-1:0] green,
  output logic [BLUE_W-1:0]  blue
);

  logic valid_d1;
  logic outside_d1;

  // Low bits index the framebuffer, the top bit marks off-screen
  assign rd_addr = {scan_y[COORD_W-1:0], scan_x[COORD_W-1:0]};

  always_ff @(posedge Clk) begin
    if (!rst_n) begin
      valid_d1    <= 1'b0;
      pixel_valid <= 1'b0;
    end else begin
      valid_d1    <= scan_valid;
      pixel_valid <= valid_d1;
    end
  end

  always_ff @(posedge Clk) begin
    outside_d1 <= (scan_x >= FB_SIZE) || (scan_y >= FB_SIZE);
    if (outside_d1) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else begin
      // RGB565 split, red on top
      red   <= rd_data[GREEN_W+BLUE_W +: RED_W];
      green <= rd_data[BLUE_W +: GREEN_W];
      blue  <= rd_data[0 +: BLUE_W];
    end
  end

endmodule

`default_nettype wire

/* src/gpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_top import gpu_pkg::*, video_pkg::*; (
  input  logic               Clk,
  input  logic               rst_n,
  input  logic               cmd_valid,
  input  logic [CMD_W-1:0]   cmd_data,
  output logic               busy,
  input  logic               scan_valid,
  input  scan_coord_t        scan_x,
  input  scan_coord_t        scan_y,
  output logic               pixel_valid,
  output logic [RED_W-1:0]   red,
  output logic [GREEN_W-1:0] green,
  output logic [BLUE_W-1:0]  blue
);

  logic     job_pending;
  fb_addr_t rd_addr;
  pixel_t   rd_data;

  draw_cmd_if draw_cmd ();
  fb_write_if fb_wr ();

  // High from the job strobe until the last pixel lands
  assign busy = draw_cmd.busy | job_pending;

  gpu_cmd_decode cmd_decode (
    .Clk       (Clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_data),
    .cmd       (draw_cmd),
    .pending   (job_pending)
  );

  gpu_raster_engine raster_engine (
    .Clk   (Clk),
    .rst_n (rst_n),
    .cmd   (draw_cmd),
    .fb    (fb_wr)
  );

  gpu_framebuffer framebuffer (
    .Clk     (Clk),
    .fb      (fb_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  gpu_scanout scanout (
    .Clk         (Clk),
    .rst_n       (rst_n),
    .scan_valid  (scan_valid),
    .scan_x      (scan_x),
    .scan_y      (scan_y),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .pixel_valid (pixel_valid),
    .red         (red),
    .green       (green),
    .blue        (blue)
  );

endmodule

`default_nettype wire

/* testbench/gpu_props.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_props import gpu_pkg::*, video_pkg::*; (
  input logic      Clk,
  input logic      rst_n,
  input logic      busy,
  input logic      we,
  input fb_addr_t  addr,
  input logic      job_valid,
  input draw_job_t job
);

  // Count of failed assertions
  int assert_failures = 0;

  // Walk starts on the top-left corner right after the strobe
  first_write_at_corner: assert property (@(posedge Clk) disable iff (!rst_n)
    job_valid |=> (we && addr == {job.y0, job.x0}))
    else begin
      assert_failures++;
      $error("first write of a job missed its top-left corner");
    end

  // Every write stays inside the ordered job rectangle
  write_addr_in_rect: assert property (@(posedge Clk) disable iff (!rst_n)
    we |-> (!$isunknown(addr) &&
            addr[COORD_W-1:0] >= job.x0 && addr[COORD_W-1:0] <= job.x1 &&
            addr[2*COORD_W-1:COORD_W] >= job.y0 && addr[2*COORD_W-1:COORD_W] <= job.y1))
    else begin
      assert_failures++;
      $error("framebuffer write address outside the job rectangle");
    end

  // Decode must hold jobs back while the engine works
  no_job_while_busy: assert property (@(posedge Clk) disable iff (!rst_n)
    job_valid |-> !busy)
    else begin
      assert_failures++;
      $error("job strobe arrived while the engine was busy");
    end

endmodule

bind gpu_raster_engine gpu_props props (
  .Clk       (Clk),
  .rst_n     (rst_n),
  .busy      (cmd.busy),
  .we        (fb.we),
  .addr      (fb.addr),
  .job_valid (cmd.job_valid),
  .job       (cmd.job)
);

`default_nettype wire

/* testbench/gpu_tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_tb_clock (
  output logic Clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 3;

  initial begin
    Clk = 1'b0;
    forever #HALF_PERIOD Clk = ~Clk;
  end

  // Release lands just after an edge, like the other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge Clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/gpu_tb_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_tb_checker import video_pkg::*; (
  input  logic                  Clk,
  input  logic                  rst_n,
  input  logic                  scan_valid,
  input  scan_coord_t           scan_x,
  input  scan_coord_t           scan_y,
  input  logic                  pixel_valid,
  input  logic [RED_W-1:0]      red,
  input  logic [GREEN_W-1:0]    green,
  input  logic [BLUE_W-1:0]     blue,
  input  pixel_t [FB_DEPTH-1:0] shadow,
  output int                    outstanding,
  output int                    checks,
  output int                    errors,
  output int                    tests,
  output int                    failed_tests
);

  scan_coord_t req_x[$];
  scan_coord_t req_y[$];
  int          req_cycle[$];
  int          cycle;
  int          test_checks;
  int          test_errors;
  string       test_name;

  // RGB565 word split into red on top, green in the middle, blue at the bottom
  function automatic logic [15:0] expected_rgb(input scan_coord_t x, input scan_coord_t y);
    pixel_t word;
    if (x >= FB_SIZE || y >= FB_SIZE) begin
      return 16'h0000;
    end
    word = shadow[int'(y) * FB_SIZE + int'(x)];
    return {word[15:11], word[10:5], word[4:0]};
  endfunction

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests++;
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("test %s done: %0d pixels checked, %0d errors", test_name, test_checks,
             test_errors);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    test_errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  initial begin
    outstanding  = 0;
    checks       = 0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    cycle        = 0;
    test_name    = "reset";
  end

  // Sampled on the falling edge, halfway between the DUT edges
  always @(negedge Clk) begin
    scan_coord_t x;
    scan_coord_t y;
    int          req_at;
    logic [15:0] exp_rgb;
    logic [15:0] act_rgb;
    cycle++;
    if (rst_n && pixel_valid) begin
      if (req_x.size() == 0) begin
        report_problem("pixel_valid came without a pending scan request");
      end else begin
        x       = req_x.pop_front();
        y       = req_y.pop_front();
        req_at  = req_cycle.pop_front();
        exp_rgb = expected_rgb(x, y);
        act_rgb = {red, green, blue};
        checks++;
        test_checks++;
        if (cycle != req_at + 2) begin
          report_problem($sformatf("result for (%0d,%0d) came %0d cycles after its request",
                                   x, y, cycle - req_at));
        end
        if (exp_rgb !== act_rgb) begin
          errors++;
          test_errors++;
          $display("Fail %s pixel (%0d,%0d) expected %h actual %h", test_name, x, y,
                   exp_rgb, act_rgb);
        end
      end
    end
    if (rst_n && scan_valid) begin
      req_x.push_back(scan_x);
      req_y.push_back(scan_y);
      req_cycle.push_back(cycle);
    end
    outstanding = req_x.size();
  end

endmodule

`default_nettype wire

/* testbench/gpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module gpu_tb import gpu_pkg::*, video_pkg::*; ();

  localparam int IDLE_LIMIT = 400;
  localparam int DRAIN_LIMIT = 16;
  localparam int RESET_LIMIT = 10;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                  Clk;
  logic                  rst_n;
  logic                  cmd_valid;
  logic [CMD_W-1:0]      cmd_data;
  logic                  busy;
  logic                  scan_valid;
  scan_coord_t           scan_x;
  scan_coord_t           scan_y;
  logic                  pixel_valid;
  logic [RED_W-1:0]      red;
  logic [GREEN_W-1:0]    green;
  logic [BLUE_W-1:0]     blue;
  logic [31:0]           lfsr_state;
  pixel_t [FB_DEPTH-1:0] shadow;
  pixel_t                shadow_color;
  int                    outstanding;
  int                    checks;
  int                    errors;
  int                    tests;
  int                    failed_tests;
  int                    total_errors;

  gpu_tb_clock clock_gen (
    .Clk   (Clk),
    .rst_n (rst_n)
  );

  gpu_top UUT (
    .Clk         (Clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_data    (cmd_data),
    .busy        (busy),
    .scan_valid  (scan_valid),
    .scan_x      (scan_x),
    .scan_y      (scan_y),
    .pixel_valid (pixel_valid),
    .red         (red),
    .green       (green),
    .blue        (blue)
  );

  gpu_tb_checker check (
    .Clk          (Clk),
    .rst_n        (rst_n),
    .scan_valid   (scan_valid),
    .scan_x       (scan_x),
    .scan_y       (scan_y),
    .pixel_valid  (pixel_valid),
    .red          (red),
    .green        (green),
    .blue         (blue),
    .shadow       (shadow),
    .outstanding  (outstanding),
    .checks       (checks),
    .errors       (errors),
    .tests        (tests),
    .failed_tests (failed_tests)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        lsb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lsb ? LFSR_TAPS : 32'd0);
      bits       = {bits[30:0], lsb};
    end
    return bits;
  endfunction

  // Shadow copy of what an accepted command does to the screen
  task automatic track_cmd(input logic [CMD_W-1:0] word);
    int xa;
    int ya;
    int xb;
    int yb;
    xa = word[15:12];
    ya = word[11:8];
    xb = word[7:4];
    yb = word[3:0];
    case (word[31:30])
      2'd0: shadow = '0;
      2'd1: shadow_color = word[15:0];
      2'd2: shadow[yb * FB_SIZE + xb] = shadow_color;
      default: begin
        for (int y = 0; y < FB_SIZE; y++) begin
          for (int x = 0; x < FB_SIZE; x++) begin
            if (((x >= xa && x <= xb) || (x >= xb && x <= xa)) &&
                ((y >= ya && y <= yb) || (y >= yb && y <= ya))) begin
              shadow[y * FB_SIZE + x] = shadow_color;
            end
          end
        end
      end
    endcase
  endtask

  task automatic stop_on_timeout(input string msg);
    $display("Timeout: %s", msg);
    $display("Test failed");
    $finish;
  endtask

  task automatic send_cmd(input logic [CMD_W-1:0] word, input bit dropped);
    @(posedge Clk);
    #2;
    cmd_valid = 1'b1;
    cmd_data  = word;
    if (!dropped) begin
      track_cmd(word);
    end
    @(posedge Clk);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < IDLE_LIMIT) begin
      @(posedge Clk);
      #2;
      cycles++;
    end
    if (busy) begin
      stop_on_timeout("busy did not fall after a draw command");
    end
  endtask

  task automatic scan_pixel(input scan_coord_t x, input scan_coord_t y);
    @(posedge Clk);
    #2;
    scan_valid = 1'b1;
    scan_x     = x;
    scan_y     = y;
  endtask

  task automatic finish_scan();
    int cycles;
    @(posedge Clk);
    #2;
    scan_valid = 1'b0;
    cycles     = 0;
    while (outstanding != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge Clk);
      #2;
      cycles++;
    end
    if (outstanding != 0) begin
      stop_on_timeout("scan results did not arrive");
    end
  endtask

  // Whole screen, then coordinates past the right and bottom edges
  task automatic scan_frame();
    for (int y = 0; y < FB_SIZE; y++) begin
      for (int x = 0; x < FB_SIZE; x++) begin
        scan_pixel(scan_coord_t'(x), scan_coord_t'(y));
      end
    end
    for (int i = FB_SIZE; i < 2 * FB_SIZE; i++) begin
      scan_pixel(scan_coord_t'(i), scan_coord_t'(i - FB_SIZE));
      scan_pixel(scan_coord_t'(i - FB_SIZE), scan_coord_t'(i));
    end
    finish_scan();
  endtask

  initial begin
    int cycles;
    cmd_valid    = 1'b0;
    cmd_data     = '0;
    scan_valid   = 1'b0;
    scan_x       = '0;
    scan_y       = '0;
    lfsr_state   = 32'd85415;
    shadow       = '0;
    shadow_color = '0;
    cycles       = 0;
    while (rst_n !== 1'b1 && cycles < RESET_LIMIT) begin
      @(negedge Clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      stop_on_timeout("reset was never released");
    end

    check.start_test("clear");
    send_cmd({OP_CLEAR, 30'd0}, 1'b0);
    wait_idle();
    scan_frame();
    check.end_test();

    check.start_test("plot");
    repeat (12) begin
      send_cmd({OP_SET_COLOR, 14'd0, 16'(take_bits(16))}, 1'b0);
      send_cmd({OP_PLOT, 22'd0, 8'(take_bits(8))}, 1'b0);
      wait_idle();
    end
    scan_frame();
    check.end_test();

    check.start_test("fill_rect");
    repeat (6) begin
      send_cmd({OP_SET_COLOR, 14'd0, 16'(take_bits(16))}, 1'b0);
      send_cmd({OP_FILL_RECT, 14'd0, 16'(take_bits(16))}, 1'b0);
      wait_idle();
    end
    // Both corner pairs given high before low
    send_cmd({OP_FILL_RECT, 14'd0, 16'hda42}, 1'b0);
    wait_idle();
    scan_frame();
    check.end_test();

    // Commands during a long fill are lost, so the plot keeps the green color
    check.start_test("drop_busy");
    send_cmd({OP_SET_COLOR, 14'd0, 16'h07e0}, 1'b0);
    send_cmd({OP_FILL_RECT, 14'd0, 16'h00f7}, 1'b0);
    if (!busy) begin
      check.report_problem("busy was low right after a fill command");
    end
    send_cmd({OP_CLEAR, 30'd0}, 1'b1);
    send_cmd({OP_SET_COLOR, 14'd0, 16'hf800}, 1'b1);
    wait_idle();
    send_cmd({OP_PLOT, 22'd0, 8'h9c}, 1'b0);
    wait_idle();
    scan_frame();
    check.end_test();

    check.start_test("scan_stream");
    repeat (40) begin
      scan_pixel(scan_coord_t'(take_bits(5)), scan_coord_t'(take_bits(5)));
    end
    finish_scan();
    check.end_test();

    total_errors = errors + UUT.raster_engine.props.assert_failures;
    $display("Summary: %0d tests, %0d failed, %0d pixels checked, %0d errors", tests,
             failed_tests, checks, total_errors);
    if (total_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* gpu_top.f */
src/video_pkg.sv
src/gpu_pkg.sv
src/gpu_ifs.sv
src/gpu_cmd_decode.sv
src/gpu_raster_engine.sv
src/gpu_framebuffer.sv
src/gpu_scanout.sv
src/gpu_top.sv
testbench/gpu_props.sv
testbench/gpu_tb_clock.sv
testbench/gpu_tb_checker.sv
testbench/gpu_tb.sv

/* Bender.yml */
package:
  name: gpu_core

sources:
  - src/video_pkg.sv
  - src/gpu_pkg.sv
  - src/gpu_ifs.sv
  - src/gpu_cmd_decode.sv
  - src/gpu_raster_engine.sv
  - src/gpu_framebuffer.sv
  - src/gpu_scanout.sv
  - src/gpu_top.sv
  - target: test
    files:
      - testbench/gpu_props.sv
      - testbench/gpu_tb_clock.sv
      - testbench/gpu_tb_checker.sv
      - testbench/gpu_tb.sv
